//--- src/mhq_pkg.sv
/*
 * MHQ shared types
 * Addresses, cache lines, queue entries, lookup requests and fills used by
 * the miss handling queue and the cache-line fetch unit
 */
package mhq_pkg;

    parameter int MHQ_DEPTH_DEFAULT = 4;

    typedef logic [31:0]  mhq_addr_t;
    typedef logic [31:0]  mhq_data_t;
    // Four words, word 0 in the low bits
    typedef logic [127:0] mhq_line_t;
    typedef logic [27:0]  mhq_line_addr_t;
    typedef logic [3:0]   mhq_offset_t;
    typedef logic [15:0]  mhq_byte_en_t;
    // Wide enough for queues of up to 8 entries
    typedef logic [2:0]   mhq_tag_t;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b011,
        LHU = 3'b100,
        SB  = 3'b101,
        SH  = 3'b110,
        SW  = 3'b111
    } mhq_lsu_func_t;

    typedef struct packed {
        logic           valid;
        logic           dirty;
        mhq_line_addr_t addr;
        mhq_line_t      data;
        mhq_byte_en_t   byte_en;
    } mhq_entry_t;

    // Request handed from the lookup stage to the execute stage
    typedef struct packed {
        logic           en;
        logic           we;
        logic           match;
        mhq_tag_t       tag;
        mhq_line_addr_t addr;
        mhq_byte_en_t   byte_en;
        mhq_line_t      data;
    } mhq_lu_req_t;

    typedef struct packed {
        mhq_tag_t       tag;
        logic           dirty;
        mhq_line_addr_t addr;
        mhq_line_t      data;
    } mhq_fill_t;

    // Advances a head or tail pointer, wrapping at the queue depth
    function automatic mhq_tag_t mhq_ptr_inc(input mhq_tag_t ptr, input int unsigned depth);
        mhq_tag_t mask;
        mask = mhq_tag_t'(depth - 1);
        return (ptr + 3'd1) & mask;
    endfunction

endpackage

//--- src/mhq_lu.sv
/*
 * MHQ lookup stage
 * Matches a miss against pending lines and the request in the execute stage,
 * then registers the tag, the full flag and the byte-write request
 */
module mhq_lu #(
    parameter int MHQ_DEPTH = mhq_pkg::MHQ_DEPTH_DEFAULT
) (
    input  logic                                clk,
    input  logic                                i_rst,
    input  mhq_pkg::mhq_entry_t [MHQ_DEPTH-1:0] i_entries,
    input  mhq_pkg::mhq_tag_t                   i_head,
    input  mhq_pkg::mhq_tag_t                   i_tail,
    input  logic                                i_deq,
    input  mhq_pkg::mhq_lu_req_t                i_ex_req,
    input  logic                                i_lookup_valid,
    input  logic                                i_lookup_dc_hit,
    input  mhq_pkg::mhq_addr_t                  i_lookup_addr,
    input  mhq_pkg::mhq_lsu_func_t              i_lookup_func,
    input  mhq_pkg::mhq_data_t                  i_lookup_data,
    output mhq_pkg::mhq_lu_req_t                o_req,
    output mhq_pkg::mhq_tag_t                   o_lookup_tag,
    output logic                                o_lookup_full
);

    import mhq_pkg::*;

    mhq_line_addr_t lu_addr;
    mhq_offset_t    lu_offset;
    logic           lu_accept;
    logic           lu_we;
    mhq_byte_en_t   lu_byte_en;
    mhq_line_t      lu_data;
    logic           ex_alloc;
    logic           bypass_hit;
    logic           entry_hit;
    mhq_tag_t       entry_tag;
    logic [3:0]     valid_cnt;
    logic [3:0]     occupied;
    mhq_tag_t       tail_eff;
    logic           lu_match;
    logic           lu_full;
    mhq_tag_t       lu_tag;

    assign lu_addr   = i_lookup_addr[31:4];
    assign lu_offset = i_lookup_addr[3:0];
    assign lu_accept = i_lookup_valid && !i_lookup_dc_hit;

    // CAM over the entries, a head being freed this cycle no longer counts
    always_comb begin
        entry_hit = 1'b0;
        entry_tag = '0;
        valid_cnt = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (i_entries[i].valid) begin
                valid_cnt = valid_cnt + 4'd1;
                if (i_entries[i].addr == lu_addr && !(i_deq && mhq_tag_t'(i) == i_head)) begin
                    entry_hit = 1'b1;
                    entry_tag = mhq_tag_t'(i);
                end
            end
        end
    end

    // An allocation in the execute stage is not yet in the entries
    assign ex_alloc   = i_ex_req.en && !i_ex_req.match;
    assign bypass_hit = ex_alloc && (i_ex_req.addr == lu_addr);
    assign tail_eff   = ex_alloc ? mhq_ptr_inc(i_tail, MHQ_DEPTH) : i_tail;
    assign occupied   = valid_cnt + 4'(ex_alloc) - 4'(i_deq);

    assign lu_match = bypass_hit || entry_hit;
    assign lu_full  = lu_accept && !lu_match && (occupied >= 4'(MHQ_DEPTH));

    always_comb begin
        if (bypass_hit) begin
            lu_tag = i_ex_req.tag;
        end else if (entry_hit) begin
            lu_tag = entry_tag;
        end else begin
            lu_tag = tail_eff;
        end
    end

    // Stores mark 1, 2 or 4 bytes at the offset, loads mark none
    always_comb begin
        lu_we = 1'b1;
        case (i_lookup_func)
            SB:      lu_byte_en = 16'h0001 << lu_offset;
            SH:      lu_byte_en = 16'h0003 << lu_offset;
            SW:      lu_byte_en = 16'h000f << lu_offset;
            default: begin
                lu_we      = 1'b0;
                lu_byte_en = '0;
            end
        endcase
    end

    assign lu_data = mhq_line_t'(i_lookup_data) << {lu_offset, 3'b000};

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_req.en      <= 1'b0;
            o_lookup_tag  <= '0;
            o_lookup_full <= 1'b0;
        end else begin
            o_req.en      <= lu_accept && !lu_full;
            o_req.we      <= lu_we;
            o_req.match   <= lu_match;
            o_req.tag     <= lu_tag;
            o_req.addr    <= lu_addr;
            o_req.byte_en <= lu_byte_en;
            o_req.data    <= lu_data;
            o_lookup_tag  <= lu_tag;
            o_lookup_full <= lu_full;
        end
    end

endmodule

//--- src/mhq_ex.sv
/*
 * MHQ execute stage
 * Holds the entry array with its head and tail, allocates or merges store
 * bytes, and merges fetched lines with stored bytes into the fill
 */
module mhq_ex #(
    parameter int MHQ_DEPTH = mhq_pkg::MHQ_DEPTH_DEFAULT
) (
    input  logic                                clk,
    input  logic                                i_rst,
    input  mhq_pkg::mhq_lu_req_t                i_req,
    output mhq_pkg::mhq_entry_t [MHQ_DEPTH-1:0] o_entries,
    output mhq_pkg::mhq_tag_t                   o_head,
    output mhq_pkg::mhq_tag_t                   o_tail,
    output logic                                o_deq,
    input  logic                                i_ccu_done,
    input  mhq_pkg::mhq_line_t                  i_ccu_data,
    output logic                                o_ccu_en,
    output mhq_pkg::mhq_line_addr_t             o_ccu_addr,
    output logic                                o_fill_en,
    output mhq_pkg::mhq_fill_t                  o_fill
);

    import mhq_pkg::*;

    localparam int PTR_W = $clog2(MHQ_DEPTH);

    mhq_entry_t [MHQ_DEPTH-1:0] entries;
    mhq_tag_t                   head;
    mhq_tag_t                   tail;
    mhq_entry_t                 req_entry;
    mhq_entry_t                 head_entry;
    logic                       deq;

    // Takes each byte of upd whose enable is set, the rest from base
    function automatic mhq_line_t merge_bytes(input mhq_line_t base, input mhq_line_t upd,
                                              input mhq_byte_en_t byte_en);
        mhq_line_t merged;
        merged = base;
        for (int b = 0; b < 16; b++) begin
            if (byte_en[b]) begin
                merged[b*8 +: 8] = upd[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Next value of the entry addressed by the request
    always_comb begin
        req_entry = entries[i_req.tag[PTR_W-1:0]];
        if (i_req.match) begin
            req_entry.dirty   = req_entry.dirty | i_req.we;
            req_entry.data    = merge_bytes(req_entry.data, i_req.data, i_req.byte_en);
            req_entry.byte_en = req_entry.byte_en | i_req.byte_en;
        end else begin
            req_entry.valid   = 1'b1;
            req_entry.dirty   = i_req.we;
            req_entry.addr    = i_req.addr;
            req_entry.data    = i_req.data;
            req_entry.byte_en = i_req.byte_en;
        end
    end

    // A store merging into the head in the fill cycle goes into the fill too
    always_comb begin
        if (i_req.en && i_req.tag == head) begin
            head_entry = req_entry;
        end else begin
            head_entry = entries[head[PTR_W-1:0]];
        end
    end

    assign deq = i_ccu_done && entries[head[PTR_W-1:0]].valid;

    assign o_fill_en    = deq;
    assign o_fill.tag   = head;
    assign o_fill.dirty = head_entry.dirty;
    assign o_fill.addr  = head_entry.addr;
    assign o_fill.data  = merge_bytes(i_ccu_data, head_entry.data, head_entry.byte_en);

    assign o_ccu_en   = entries[head[PTR_W-1:0]].valid && !i_ccu_done;
    assign o_ccu_addr = entries[head[PTR_W-1:0]].addr;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
            head <= '0;
            tail <= '0;
        end else begin
            if (i_req.en) begin
                entries[i_req.tag[PTR_W-1:0]] <= req_entry;
            end
            // Freeing the head comes last so that it wins over a merge into it
            if (deq) begin
                entries[head[PTR_W-1:0]].valid <= 1'b0;
                head <= mhq_ptr_inc(head, MHQ_DEPTH);
            end
            if (i_req.en && !i_req.match) begin
                tail <= mhq_ptr_inc(tail, MHQ_DEPTH);
            end
        end
    end

    assign o_entries = entries;
    assign o_head    = head;
    assign o_tail    = tail;
    assign o_deq     = deq;

endmodule

//--- src/mhq.sv
/*
 * Miss handling queue
 * Two stage pipeline of lookup and execute that tracks missed lines
 */
module mhq #(
    parameter int MHQ_DEPTH = mhq_pkg::MHQ_DEPTH_DEFAULT
) (
    input  logic                    clk,
    input  logic                    i_rst,

    // Lookups from the load-store unit
    input  logic                    i_lookup_valid,
    input  logic                    i_lookup_dc_hit,
    input  mhq_pkg::mhq_addr_t      i_lookup_addr,
    input  mhq_pkg::mhq_lsu_func_t  i_lookup_func,
    input  mhq_pkg::mhq_data_t      i_lookup_data,
    output mhq_pkg::mhq_tag_t       o_lookup_tag,
    output logic                    o_lookup_full,

    output logic                    o_fill_en,
    output mhq_pkg::mhq_fill_t      o_fill,

    // Line fetch requests and returned lines
    input  logic                    i_ccu_done,
    input  mhq_pkg::mhq_line_t      i_ccu_data,
    output logic                    o_ccu_en,
    output mhq_pkg::mhq_line_addr_t o_ccu_addr
);

    import mhq_pkg::*;

    mhq_entry_t [MHQ_DEPTH-1:0] entries;
    mhq_tag_t                   head;
    mhq_tag_t                   tail;
    logic                       deq;
    mhq_lu_req_t                lu_req;

    mhq_lu #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) mhq_lu_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_entries(entries),
        .i_head(head),
        .i_tail(tail),
        .i_deq(deq),
        .i_ex_req(lu_req),
        .i_lookup_valid(i_lookup_valid),
        .i_lookup_dc_hit(i_lookup_dc_hit),
        .i_lookup_addr(i_lookup_addr),
        .i_lookup_func(i_lookup_func),
        .i_lookup_data(i_lookup_data),
        .o_req(lu_req),
        .o_lookup_tag(o_lookup_tag),
        .o_lookup_full(o_lookup_full)
    );

    mhq_ex #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) mhq_ex_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_req(lu_req),
        .o_entries(entries),
        .o_head(head),
        .o_tail(tail),
        .o_deq(deq),
        .i_ccu_done(i_ccu_done),
        .i_ccu_data(i_ccu_data),
        .o_ccu_en(o_ccu_en),
        .o_ccu_addr(o_ccu_addr),
        .o_fill_en(o_fill_en),
        .o_fill(o_fill)
    );

endmodule

//--- src/ccu.sv
/*
 * Cache-line fetch unit
 * Wishbone classic master that reads the four words of a line in order
 */
module ccu (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_en,
    input  mhq_pkg::mhq_line_addr_t i_addr,
    output logic                    o_done,
    output mhq_pkg::mhq_line_t      o_data,

    // Wishbone master
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic                    o_wb_we,
    output mhq_pkg::mhq_addr_t      o_wb_adr,
    input  mhq_pkg::mhq_data_t      i_wb_dat,
    input  logic                    i_wb_ack
);

    import mhq_pkg::*;

    typedef enum logic [1:0] {
        CCU_IDLE = 2'b00,
        CCU_READ = 2'b01,
        CCU_DONE = 2'b10
    } ccu_state_t;

    ccu_state_t     state;
    logic [1:0]     beat;
    mhq_line_addr_t line_addr;
    mhq_line_t      line_data;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= CCU_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                CCU_IDLE: begin
                    if (i_en) begin
                        state <= CCU_READ;
                        beat  <= '0;
                    end
                end
                CCU_READ: begin
                    if (i_wb_ack) begin
                        beat <= beat + 2'd1;
                        if (beat == 2'd3) begin
                            state <= CCU_DONE;
                        end
                    end
                end
                CCU_DONE: state <= CCU_IDLE;
                default:  state <= CCU_IDLE;
            endcase
        end
    end

    // Line address is captured at the start, words land as they are acked
    always_ff @(posedge clk) begin
        if (state == CCU_IDLE && i_en) begin
            line_addr <= i_addr;
        end
        if (state == CCU_READ && i_wb_ack) begin
            line_data[beat*32 +: 32] <= i_wb_dat;
        end
    end

    assign o_wb_cyc = (state == CCU_READ);
    assign o_wb_stb = (state == CCU_READ);
    assign o_wb_we  = 1'b0;
    assign o_wb_adr = {line_addr, beat, 2'b00};

    assign o_done = (state == CCU_DONE);
    assign o_data = line_data;

endmodule

//--- src/mhq_top.sv
/*
 * Miss handling subsystem
 * Joins the miss handling queue with the line fetch unit on Wishbone
 */
module mhq_top #(
    parameter int MHQ_DEPTH = mhq_pkg::MHQ_DEPTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_lookup_valid,
    input  logic                   i_lookup_dc_hit,
    input  mhq_pkg::mhq_addr_t     i_lookup_addr,
    input  mhq_pkg::mhq_lsu_func_t i_lookup_func,
    input  mhq_pkg::mhq_data_t     i_lookup_data,
    output mhq_pkg::mhq_tag_t      o_lookup_tag,
    output logic                   o_lookup_full,
    output logic                   o_fill_en,
    output mhq_pkg::mhq_fill_t     o_fill,
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic                   o_wb_we,
    output mhq_pkg::mhq_addr_t     o_wb_adr,
    input  mhq_pkg::mhq_data_t     i_wb_dat,
    input  logic                   i_wb_ack
);

    import mhq_pkg::*;

    logic           ccu_en;
    mhq_line_addr_t ccu_addr;
    logic           ccu_done;
    mhq_line_t      ccu_data;

    mhq #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) mhq_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_lookup_valid(i_lookup_valid),
        .i_lookup_dc_hit(i_lookup_dc_hit),
        .i_lookup_addr(i_lookup_addr),
        .i_lookup_func(i_lookup_func),
        .i_lookup_data(i_lookup_data),
        .o_lookup_tag(o_lookup_tag),
        .o_lookup_full(o_lookup_full),
        .o_fill_en(o_fill_en),
        .o_fill(o_fill),
        .i_ccu_done(ccu_done),
        .i_ccu_data(ccu_data),
        .o_ccu_en(ccu_en),
        .o_ccu_addr(ccu_addr)
    );

    ccu ccu_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_en(ccu_en),
        .i_addr(ccu_addr),
        .o_done(ccu_done),
        .o_data(ccu_data),
        .o_wb_cyc(o_wb_cyc),
        .o_wb_stb(o_wb_stb),
        .o_wb_we(o_wb_we),
        .o_wb_adr(o_wb_adr),
        .i_wb_dat(i_wb_dat),
        .i_wb_ack(i_wb_ack)
    );

endmodule

//--- dv/mhq_tb_mem.sv
/*
 * Wishbone slave memory for the MHQ testbench
 * Answers each read with its address mixed with a fixed pattern, after a
 * delay of 0 to 3 cycles chosen by the testbench
 */
module mhq_tb_mem #(
    parameter logic [31:0] MEM_PATTERN = 32'h3c5a_96e1
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic [31:0] i_wb_adr,
    input  logic [1:0]  i_ack_delay,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack
);

    logic [1:0] wait_cnt;
    logic [1:0] beat_delay;
    logic [1:0] delay_now;

    // The delay is taken when a beat starts and held until its ack
    assign delay_now = (wait_cnt == 2'd0) ? i_ack_delay : beat_delay;

    initial begin
        o_wb_dat   = '0;
        o_wb_ack   = 1'b0;
        wait_cnt   = '0;
        beat_delay = '0;
    end

    always @(posedge clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            wait_cnt <= '0;
        end else if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
            if (wait_cnt == 2'd0) begin
                beat_delay <= i_ack_delay;
            end
            if (wait_cnt == delay_now) begin
                o_wb_ack <= 1'b1;
                o_wb_dat <= i_wb_adr ^ MEM_PATTERN;
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else begin
            // Ack lasts one cycle so the master can move to the next word
            o_wb_ack <= 1'b0;
        end
    end

endmodule

//--- dv/mhq_tb.sv
/*
 * MHQ subsystem testbench
 * Random lookups from a fixed seed are checked against a queue model,
 * together with the fills and the Wishbone reads behind them
 */
module mhq_tb;

    import mhq_pkg::*;

    localparam int          DEPTH         = 4;
    localparam int          NUM_LOOKUPS   = 3000;
    localparam int          RUN_TIMEOUT   = 20000;
    localparam int          DRAIN_TIMEOUT = 500;
    localparam logic [31:0] MEM_PATTERN   = 32'h3c5a_96e1;
    // Six lines for a queue of four, so merges and a full queue are common
    localparam mhq_line_addr_t LINE_POOL [6] = '{
        28'h0000100, 28'h0000101, 28'h0000240, 28'h00a0007, 28'h1234560, 28'hfffffff
    };

    typedef struct packed {
        mhq_tag_t       tag;
        logic           dirty;
        mhq_line_addr_t addr;
        mhq_line_t      data;
        mhq_byte_en_t   byte_en;
    } model_entry_t;

    logic          clk;
    logic          rst;
    logic          lookup_valid;
    logic          lookup_dc_hit;
    mhq_addr_t     lookup_addr;
    mhq_lsu_func_t lookup_func;
    mhq_data_t     lookup_data;
    mhq_tag_t      lookup_tag;
    logic          lookup_full;
    logic          fill_en;
    mhq_fill_t     fill;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    mhq_addr_t     wb_adr;
    mhq_data_t     wb_dat;
    logic          wb_ack;
    logic [1:0]    ack_delay;

    logic [31:0]   lcg_state;
    model_entry_t  model_q[$];
    mhq_addr_t     wb_beats[$];
    mhq_tag_t      model_tail;
    logic          res_pending;
    mhq_tag_t      exp_tag;
    logic          exp_full;
    int            issued;
    int            cycles;

    mhq_top #(
        .MHQ_DEPTH(DEPTH)
    ) dut0 (
        .clk(clk),
        .i_rst(rst),
        .i_lookup_valid(lookup_valid),
        .i_lookup_dc_hit(lookup_dc_hit),
        .i_lookup_addr(lookup_addr),
        .i_lookup_func(lookup_func),
        .i_lookup_data(lookup_data),
        .o_lookup_tag(lookup_tag),
        .o_lookup_full(lookup_full),
        .o_fill_en(fill_en),
        .o_fill(fill),
        .o_wb_cyc(wb_cyc),
        .o_wb_stb(wb_stb),
        .o_wb_we(wb_we),
        .o_wb_adr(wb_adr),
        .i_wb_dat(wb_dat),
        .i_wb_ack(wb_ack)
    );

    mhq_tb_mem #(
        .MEM_PATTERN(MEM_PATTERN)
    ) mem0 (
        .clk(clk),
        .i_rst(rst),
        .i_wb_cyc(wb_cyc),
        .i_wb_stb(wb_stb),
        .i_wb_adr(wb_adr),
        .i_ack_delay(ack_delay),
        .o_wb_dat(wb_dat),
        .o_wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int store_size(input mhq_lsu_func_t func);
        case (func)
            SB:      return 1;
            SH:      return 2;
            SW:      return 4;
            default: return 0;
        endcase
    endfunction

    // Line as the memory returns it with word 0 from the lowest address
    function automatic mhq_line_t memory_line(input mhq_line_addr_t addr);
        mhq_line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = {addr, 2'(w), 2'b00} ^ MEM_PATTERN;
        end
        return line;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_tag(input string name, input mhq_tag_t got, input mhq_tag_t exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s got=%b expected=%b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fill(input string name, input mhq_fill_t got, input mhq_fill_t exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input mhq_addr_t got, input mhq_addr_t exp);
        if (got !== exp) begin
            $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_lookup(input logic active);
        logic [31:0]   r;
        mhq_offset_t   off;
        mhq_lsu_func_t func;
        logic          valid;
        r = lcg_rand();
        ack_delay <= r[31:30];
        r = lcg_rand();
        func  = mhq_lsu_func_t'(r[31:29]);
        off   = r[28:25];
        valid = active && (r[24:23] != 2'b00);
        // Natural alignment for halfwords and words
        case (func)
            LH, LHU, SH: off = off & 4'he;
            LW, SW:      off = off & 4'hc;
            default:     off = off;
        endcase
        lookup_valid  <= valid;
        lookup_dc_hit <= (r[22:20] == 3'b000);
        lookup_addr   <= {LINE_POOL[int'(r[19:8]) % 6], off};
        lookup_func   <= func;
        lookup_data   <= lcg_rand();
        if (valid) begin
            issued++;
        end
    endtask

    // Runs at each rising edge and sees the outputs of the cycle just ended
    task automatic step(input logic active);
        model_entry_t   e;
        mhq_fill_t      exp_fill;
        mhq_line_addr_t line;
        int             idx;
        int             off;
        int             size;

        if (res_pending) begin
            check_bit("o_lookup_full", lookup_full, exp_full);
            if (!exp_full) begin
                check_tag("o_lookup_tag", lookup_tag, exp_tag);
            end
        end else begin
            check_bit("o_lookup_full", lookup_full, 1'b0);
        end

        if (wb_cyc) begin
            check_bit("o_wb_we", wb_we, 1'b0);
            check_bit("o_wb_stb", wb_stb, 1'b1);
            if (wb_ack) begin
                wb_beats.push_back(wb_adr);
            end
        end

        if (fill_en) begin
            if (model_q.size() == 0) begin
                $display("A fill came out at time %0t with no line pending", $time);
                abort_run();
            end else begin
                e = model_q.pop_front();
                exp_fill.tag   = e.tag;
                exp_fill.dirty = e.dirty;
                exp_fill.addr  = e.addr;
                exp_fill.data  = memory_line(e.addr);
                for (int b = 0; b < 16; b++) begin
                    if (e.byte_en[b]) begin
                        exp_fill.data[b*8 +: 8] = e.data[b*8 +: 8];
                    end
                end
                check_fill("o_fill", fill, exp_fill);
                if (wb_beats.size() != 4) begin
                    $display("The fill at time %0t followed %0d Wishbone reads, not four",
                             $time, wb_beats.size());
                    abort_run();
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        check_addr("o_wb_adr", wb_beats[w], {e.addr, 2'(w), 2'b00});
                    end
                    wb_beats.delete();
                end
            end
        end

        // The fill of this cycle is popped before the presented lookup is applied
        res_pending = lookup_valid && !lookup_dc_hit;
        if (res_pending) begin
            line = lookup_addr[31:4];
            off  = int'(lookup_addr[3:0]);
            size = store_size(lookup_func);
            idx  = -1;
            for (int i = 0; i < model_q.size(); i++) begin
                if (model_q[i].addr == line) begin
                    idx = i;
                end
            end
            exp_full = 1'b0;
            e = '0;
            if (idx >= 0) begin
                e = model_q[idx];
            end else if (model_q.size() >= DEPTH) begin
                exp_full = 1'b1;
            end else begin
                e.tag  = model_tail;
                e.addr = line;
                model_tail = mhq_tag_t'((int'(model_tail) + 1) % DEPTH);
            end
            if (!exp_full) begin
                exp_tag = e.tag;
                e.dirty = e.dirty || (size != 0);
                for (int k = 0; k < size; k++) begin
                    e.byte_en[off + k]      = 1'b1;
                    e.data[(off + k)*8 +: 8] = lookup_data[k*8 +: 8];
                end
                if (idx >= 0) begin
                    model_q[idx] = e;
                end else begin
                    model_q.push_back(e);
                end
            end
        end

        drive_lookup(active);
    endtask

    initial begin
        lcg_state     = 32'h5b78;
        rst           = 1'b1;
        lookup_valid  = 1'b0;
        lookup_dc_hit = 1'b0;
        lookup_addr   = '0;
        lookup_func   = LB;
        lookup_data   = '0;
        ack_delay     = '0;
        model_tail    = '0;
        res_pending   = 1'b0;
        exp_tag       = '0;
        exp_full      = 1'b0;
        issued        = 0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_bit("o_fill_en", fill_en, 1'b0);
        check_bit("o_lookup_full", lookup_full, 1'b0);
        check_bit("o_wb_cyc", wb_cyc, 1'b0);
        check_bit("o_wb_stb", wb_stb, 1'b0);
        check_tag("o_lookup_tag", lookup_tag, '0);

        cycles = 0;
        while (issued < NUM_LOOKUPS) begin
            if (cycles >= RUN_TIMEOUT) begin
                $display("Timeout: only %0d lookups were issued in %0d cycles",
                         issued, cycles);
                abort_run();
            end else begin
                step(1'b1);
                @(posedge clk);
                cycles++;
            end
        end

        cycles = 0;
        while (model_q.size() != 0 || res_pending) begin
            if (cycles >= DRAIN_TIMEOUT) begin
                $display("Timeout: the queue did not drain, %0d lines still pending",
                         model_q.size());
                abort_run();
            end else begin
                step(1'b0);
                @(posedge clk);
                cycles++;
            end
        end

        if (wb_beats.size() != 0) begin
            $display("Wishbone reads were left over with no fill after them");
            abort_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
src/mhq_pkg.sv
src/mhq_lu.sv
src/mhq_ex.sv
src/mhq.sv
src/ccu.sv
src/mhq_top.sv
dv/mhq_tb_mem.sv
dv/mhq_tb.sv

//--- run.sh
#!/bin/sh
# Builds the MHQ testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module mhq_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmhq_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
